/* verilog/mmc5_cpu_pkg.sv */
// MMC5 CPU bus cycle type and register address map
`default_nettype none

package mmc5_cpu_pkg;

	// One CPU cycle as seen on the cartridge edge
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  data;
		logic        rd;   // CPU reads this cycle
		logic        wr;   // CPU writes this cycle
	} cpu_bus_t;

	// Upper address bits of the register window $5000-$53FF
	localparam logic [5:0] REG_WINDOW_HI = 6'b010100;

	// Offsets inside the register window
	localparam logic [9:0] REG_PRG_MODE     = 10'h100;
	localparam logic [9:0] REG_PROTECT_1    = 10'h102; // Pattern %10 unlocks
	localparam logic [9:0] REG_PROTECT_2    = 10'h103; // Pattern %01 unlocks
	localparam logic [9:0] REG_PRG_RAM_BANK = 10'h113;
	localparam logic [9:0] REG_PRG_BANK_0   = 10'h114;
	localparam logic [9:0] REG_PRG_BANK_1   = 10'h115;
	localparam logic [9:0] REG_PRG_BANK_2   = 10'h116;
	localparam logic [9:0] REG_PRG_BANK_3   = 10'h117;
	localparam logic [9:0] REG_IRQ_SCANLINE = 10'h203;
	localparam logic [9:0] REG_IRQ_STATUS   = 10'h204; // Bit 7 is IRQ enable on write
	localparam logic [9:0] REG_MUL_A        = 10'h205;
	localparam logic [9:0] REG_MUL_B        = 10'h206;

	// Full addresses decoded on the read side
	localparam logic [15:0] ADDR_IRQ_STATUS = 16'h5204;
	localparam logic [15:0] ADDR_MUL_LO     = 16'h5205;
	localparam logic [15:0] ADDR_MUL_HI     = 16'h5206;

	// NMI vector fetch, low byte of the pair $FFFA/$FFFB
	localparam logic [15:0] ADDR_NMI_VECTOR = 16'hFFFA;

	// Value returned when the mapper does not drive the bus
	localparam logic [7:0] OPEN_BUS = 8'hFF;

endpackage

`default_nettype wire

/* verilog/mmc5_map_pkg.sv */
// MMC5 mapper configuration type with PRG banking and scanline constants
`default_nettype none

package mmc5_map_pkg;

	// PRG banking modes as written to $5100
	typedef enum logic [1:0] {
		PRG_32K    = 2'd0,
		PRG_16K    = 2'd1,
		PRG_16K_8K = 2'd2,
		PRG_8K     = 2'd3
	} prg_mode_t;

	// Configuration seen by the PRG mapping logic
	typedef struct packed {
		prg_mode_t  prg_mode;
		logic       ram_we;        // Both protect patterns correct
		logic [2:0] prg_ram_bank;
		logic [7:0] prg_bank_0;    // Bit 7 set selects ROM
		logic [7:0] prg_bank_1;
		logic [7:0] prg_bank_2;
		logic [6:0] prg_bank_3;    // Always ROM
	} map_cfg_t;

	// Page select width, ROM flag in the top bit
	localparam int PRG_PAGE_W = 8;

	// PRG address out, 8 kB pages over 4 MB
	localparam int PRG_AOUT_W = 22;

	// Upper page bits where PRG RAM lives in the address space
	localparam logic [5:0] RAM_BASE_PAGE = 6'b111100;

	// Scanline that takes the mapper out of frame
	localparam logic [7:0] LAST_SCANLINE = 8'd239;

	// Same-address nametable reads before detection is armed
	localparam logic [1:0] NT_REPEAT = 2'd3;

	// Idle counter value at which the frame is considered over
	localparam logic [1:0] IDLE_CE_LIMIT = 2'd2;

endpackage

`default_nettype wire

/* verilog/mmc5_reg_file.sv */
// MMC5 register file, decodes CPU writes in $5100-$5206 into the mapper configuration
`timescale 1ns/1ns
`default_nettype none

module mmc5_reg_file
	import mmc5_cpu_pkg::*;
	import mmc5_map_pkg::*;
(
	input  logic       clk,
	input  logic       arst_n_i,
	input  logic       ce_i,
	input  cpu_bus_t   cpu_i,
	output map_cfg_t   cfg_o,
	output logic [7:0] irq_scanline_o,
	output logic       irq_enable_o,
	output logic [7:0] mul_a_o,
	output logic [7:0] mul_b_o
);

	prg_mode_t  prg_mode;
	logic       protect_1;
	logic       protect_2;
	logic [2:0] prg_ram_bank;
	logic [7:0] prg_bank_0;
	logic [7:0] prg_bank_1;
	logic [7:0] prg_bank_2;
	logic [6:0] prg_bank_3;
	logic       reg_wr;

	assign reg_wr = ce_i & cpu_i.wr & (cpu_i.addr[15:10] == REG_WINDOW_HI);

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			prg_mode       <= PRG_8K;   // Last bank at $E000 for the reset vector
			protect_1      <= 1'b0;
			protect_2      <= 1'b0;
			prg_ram_bank   <= '0;
			prg_bank_0     <= '0;
			prg_bank_1     <= '0;
			prg_bank_2     <= '0;
			prg_bank_3     <= '1;
			irq_scanline_o <= '0;
			irq_enable_o   <= 1'b0;
			mul_a_o        <= '0;
			mul_b_o        <= '0;
		end else if (reg_wr) begin
			case (cpu_i.addr[9:0])
				REG_PRG_MODE:     prg_mode       <= prg_mode_t'(cpu_i.data[1:0]);
				REG_PROTECT_1:    protect_1      <= (cpu_i.data[1:0] == 2'b10);
				REG_PROTECT_2:    protect_2      <= (cpu_i.data[1:0] == 2'b01);
				REG_PRG_RAM_BANK: prg_ram_bank   <= cpu_i.data[2:0];
				REG_PRG_BANK_0:   prg_bank_0     <= cpu_i.data;
				REG_PRG_BANK_1:   prg_bank_1     <= cpu_i.data;
				REG_PRG_BANK_2:   prg_bank_2     <= cpu_i.data;
				REG_PRG_BANK_3:   prg_bank_3     <= cpu_i.data[6:0];
				REG_IRQ_SCANLINE: irq_scanline_o <= cpu_i.data;
				REG_IRQ_STATUS:   irq_enable_o   <= cpu_i.data[7];
				REG_MUL_A:        mul_a_o        <= cpu_i.data;
				REG_MUL_B:        mul_b_o        <= cpu_i.data;
				default: begin
				end
			endcase
		end
	end

	always_comb begin
		cfg_o.prg_mode     = prg_mode;
		cfg_o.ram_we       = protect_1 & protect_2; // RAM writes need both unlocks
		cfg_o.prg_ram_bank = prg_ram_bank;
		cfg_o.prg_bank_0   = prg_bank_0;
		cfg_o.prg_bank_1   = prg_bank_1;
		cfg_o.prg_bank_2   = prg_bank_2;
		cfg_o.prg_bank_3   = prg_bank_3;
	end

	// Banking mode must always resolve to a known value once out of reset
	a_prg_mode_known: assert property (
		@(posedge clk) disable iff (!arst_n_i)
		!$isunknown(cfg_o.prg_mode)
	) else $error("prg_mode is unknown after reset");

endmodule

`default_nettype wire

/* verilog/mmc5_prg_map.sv */
// MMC5 PRG mapper that selects the 8 kB page for $6000-$FFFF and gates RAM writes
`timescale 1ns/1ns
`default_nettype none

module mmc5_prg_map
	import mmc5_cpu_pkg::*;
	import mmc5_map_pkg::*;
(
	input  cpu_bus_t              cpu_i,
	input  map_cfg_t              cfg_i,
	output logic [PRG_AOUT_W-1:0] prg_aout_o,
	output logic                  prg_allow_o
);

	logic [PRG_PAGE_W-1:0] page; // Top bit set means ROM
	logic                  a14;
	logic                  a13;

	assign a14 = cpu_i.addr[14];
	assign a13 = cpu_i.addr[13];

	always_comb begin
		if (!cpu_i.addr[15]) begin
			page = {5'b00000, cfg_i.prg_ram_bank}; // $6000-$7FFF in every mode
		end else begin
			case (cfg_i.prg_mode)
				PRG_32K: begin
					page = {1'b1, cfg_i.prg_bank_3[6:2], a14, a13};
				end
				PRG_16K: begin
					if (a14) begin
						page = {1'b1, cfg_i.prg_bank_3[6:1], a13};
					end else begin
						page = {cfg_i.prg_bank_1[7:1], a13};
					end
				end
				PRG_16K_8K: begin
					if (!a14) begin
						page = {cfg_i.prg_bank_1[7:1], a13};
					end else if (a13) begin
						page = {1'b1, cfg_i.prg_bank_3};
					end else begin
						page = cfg_i.prg_bank_2;
					end
				end
				default: begin // Four 8 kB windows
					case ({a14, a13})
						2'b00:   page = cfg_i.prg_bank_0;
						2'b01:   page = cfg_i.prg_bank_1;
						2'b10:   page = cfg_i.prg_bank_2;
						default: page = {1'b1, cfg_i.prg_bank_3};
					endcase
				end
			endcase
		end
	end

	always_comb begin
		if (page[PRG_PAGE_W-1]) begin
			prg_aout_o = {2'b00, page[6:0], cpu_i.addr[12:0]};
		end else begin
			prg_aout_o = {RAM_BASE_PAGE, page[2:0], cpu_i.addr[12:0]}; // 64 kB of RAM
		end
	end

	always_comb begin
		prg_allow_o = (cpu_i.addr >= 16'h6000) &&
			(!cpu_i.wr || (!page[PRG_PAGE_W-1] && cfg_i.ram_we));
	end

endmodule

`default_nettype wire

/* verilog/mmc5_scanline_irq.sv */
// MMC5 scanline detector that tracks the PPU frame from nametable fetches and raises the IRQ
`timescale 1ns/1ns
`default_nettype none

module mmc5_scanline_irq
	import mmc5_cpu_pkg::*;
	import mmc5_map_pkg::*;
(
	input  logic        clk,
	input  logic        arst_n_i,
	input  logic        ce_i,
	input  cpu_bus_t    cpu_i,
	input  logic        chr_rd_i,
	input  logic [13:0] chr_addr_i,
	input  logic [7:0]  irq_scanline_i,
	input  logic        irq_enable_i,
	output logic        in_frame_o,
	output logic        irq_pending_o,
	output logic        irq_o
);

	logic        last_chr_rd;
	logic        chr_rise;
	logic        is_nt_read;
	logic [11:0] last_nt_addr;
	logic [1:0]  nt_read_cnt;   // Same-address nametable reads
	logic [1:0]  idle_cnt;      // CPU cycles without a PPU read
	logic [7:0]  scanline;
	logic        in_frame;
	logic        last_in_frame;
	logic        irq_pending;
	logic        pending_clear;
	logic        nmi_read;
	logic        status_read;

	assign chr_rise    = chr_rd_i & ~last_chr_rd;
	assign is_nt_read  = (chr_addr_i[13:12] == 2'b10); // $2xxx
	assign nmi_read    = cpu_i.rd & ({cpu_i.addr[15:1], 1'b0} == ADDR_NMI_VECTOR);
	assign status_read = cpu_i.rd & (cpu_i.addr == ADDR_IRQ_STATUS);

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			last_chr_rd   <= 1'b0;
			last_nt_addr  <= '0;
			nt_read_cnt   <= '0;
			idle_cnt      <= '0;
			scanline      <= '0;
			in_frame      <= 1'b0;
			last_in_frame <= 1'b0;
			irq_pending   <= 1'b0;
			pending_clear <= 1'b0;
		end else begin
			last_chr_rd   <= chr_rd_i;
			last_in_frame <= in_frame;

			if (chr_rise) begin
				last_nt_addr <= chr_addr_i[11:0];
				if (nt_read_cnt != NT_REPEAT) begin
					nt_read_cnt <= nt_read_cnt + 2'd1;
				end else if (!in_frame) begin
					in_frame <= 1'b1;      // First line of the frame
					scanline <= '0;
				end else if (scanline == LAST_SCANLINE) begin
					in_frame <= 1'b0;
				end else begin
					scanline <= scanline + 8'd1;
					if (scanline + 8'd1 == irq_scanline_i) begin
						irq_pending <= 1'b1;
					end
				end
				// Pattern or attribute fetch, or a new address, restarts the run
				if (!is_nt_read ||
					(nt_read_cnt != 2'd0 && last_nt_addr != chr_addr_i[11:0])) begin
					nt_read_cnt <= '0;
				end
			end

			if (ce_i) begin
				if (chr_rd_i) begin
					idle_cnt <= '0;
				end else if (in_frame) begin
					idle_cnt <= idle_cnt + 2'd1;
					if (idle_cnt == IDLE_CE_LIMIT) begin
						in_frame <= 1'b0;  // PPU stopped rendering
					end
				end
				if (nmi_read) begin
					in_frame <= 1'b0;
				end
				if (pending_clear) begin
					irq_pending   <= 1'b0;
					pending_clear <= 1'b0;
				end
				if (status_read) begin
					pending_clear <= 1'b1; // Acts on the next CPU cycle
				end
			end

			// Falling edge of in_frame
			if (last_in_frame && !in_frame) begin
				nt_read_cnt <= '0;
				idle_cnt    <= '0;
				irq_pending <= 1'b0;
			end
		end
	end

	assign in_frame_o    = in_frame;
	assign irq_pending_o = irq_pending;
	assign irq_o         = irq_pending & irq_enable_i;

	// Pending never outlives the frame beyond the clearing cycle
	a_pending_in_frame: assert property (
		@(posedge clk) disable iff (!arst_n_i)
		!in_frame && !$past(in_frame) |-> !irq_pending
	) else $error("irq_pending held outside the frame");

endmodule

`default_nettype wire

/* verilog/mmc5_cpu_readback.sv */
// MMC5 CPU read side with the 8x8 multiplier and read data mux for $5204-$5206
`timescale 1ns/1ns
`default_nettype none

module mmc5_cpu_readback
	import mmc5_cpu_pkg::*;
(
	input  cpu_bus_t   cpu_i,
	input  logic [7:0] mul_a_i,
	input  logic [7:0] mul_b_i,
	input  logic       in_frame_i,
	input  logic       irq_pending_i,
	output logic [7:0] prg_dout_o,
	output logic       prg_bus_write_o
);

	localparam int MUL_W = 8;

	logic [2*MUL_W-1:0] product;

	assign product = (2*MUL_W)'(mul_a_i) * (2*MUL_W)'(mul_b_i); // Unsigned

	always_comb begin
		prg_bus_write_o = 1'b1;
		if (cpu_i.addr == ADDR_IRQ_STATUS) begin
			prg_dout_o = {irq_pending_i, in_frame_i, 6'b111111};
		end else if (cpu_i.addr == ADDR_MUL_LO) begin
			prg_dout_o = product[MUL_W-1:0];
		end else if (cpu_i.addr == ADDR_MUL_HI) begin
			prg_dout_o = product[2*MUL_W-1:MUL_W];
		end else begin
			prg_dout_o      = OPEN_BUS;
			prg_bus_write_o = 1'b0; // Leave the bus to ROM/RAM
		end
	end

endmodule

`default_nettype wire

/* verilog/mmc5_top.sv */
// MMC5 mapper CPU core top level with registers, PRG mapping, scanline IRQ and readback
`timescale 1ns/1ns
`default_nettype none

module mmc5_top
	import mmc5_cpu_pkg::*;
	import mmc5_map_pkg::*;
(
	input  logic                  clk,
	input  logic                  arst_n_i,
	input  logic                  ce_i,
	input  cpu_bus_t              cpu_i,
	input  logic                  chr_rd_i,
	input  logic [13:0]           chr_addr_i,
	output logic [PRG_AOUT_W-1:0] prg_aout_o,
	output logic                  prg_allow_o,
	output logic [7:0]            prg_dout_o,
	output logic                  prg_bus_write_o,
	output logic                  irq_o
);

	map_cfg_t   cfg;
	logic [7:0] irq_scanline;
	logic       irq_enable;
	logic [7:0] mul_a;
	logic [7:0] mul_b;
	logic       in_frame;
	logic       irq_pending;

	mmc5_reg_file u_reg_file (
		.clk            (clk),
		.arst_n_i       (arst_n_i),
		.ce_i           (ce_i),
		.cpu_i          (cpu_i),
		.cfg_o          (cfg),
		.irq_scanline_o (irq_scanline),
		.irq_enable_o   (irq_enable),
		.mul_a_o        (mul_a),
		.mul_b_o        (mul_b)
	);

	mmc5_prg_map u_prg_map (
		.cpu_i       (cpu_i),
		.cfg_i       (cfg),
		.prg_aout_o  (prg_aout_o),
		.prg_allow_o (prg_allow_o)
	);

	mmc5_scanline_irq u_scanline_irq (
		.clk            (clk),
		.arst_n_i       (arst_n_i),
		.ce_i           (ce_i),
		.cpu_i          (cpu_i),
		.chr_rd_i       (chr_rd_i),
		.chr_addr_i     (chr_addr_i),
		.irq_scanline_i (irq_scanline),
		.irq_enable_i   (irq_enable),
		.in_frame_o     (in_frame),
		.irq_pending_o  (irq_pending),
		.irq_o          (irq_o)
	);

	mmc5_cpu_readback u_cpu_readback (
		.cpu_i           (cpu_i),
		.mul_a_i         (mul_a),
		.mul_b_i         (mul_b),
		.in_frame_i      (in_frame),
		.irq_pending_i   (irq_pending),
		.prg_dout_o      (prg_dout_o),
		.prg_bus_write_o (prg_bus_write_o)
	);

endmodule

`default_nettype wire

/* verification/tb_mmc5_top.sv */
// MMC5 CPU core testbench, runs the command file and checks PRG mapping, readback and scanline IRQ
`timescale 1ns/1ns
`default_nettype none

module tb_mmc5_top
	import mmc5_cpu_pkg::*;
	import mmc5_map_pkg::*;
();

	localparam int MAX_COMMANDS = 1000;
	localparam int IRQ_TIMEOUT  = 64;  // Clock cycles

	logic                  clk;
	logic                  arst_n_i;
	logic                  ce_i;
	cpu_bus_t              cpu_i;
	logic                  chr_rd_i;
	logic [13:0]           chr_addr_i;
	logic [PRG_AOUT_W-1:0] prg_aout_o;
	logic                  prg_allow_o;
	logic [7:0]            prg_dout_o;
	logic                  prg_bus_write_o;
	logic                  irq_o;

	int     error_count;
	integer seed;

	mmc5_top u_mmc5_top (
		.clk             (clk),
		.arst_n_i        (arst_n_i),
		.ce_i            (ce_i),
		.cpu_i           (cpu_i),
		.chr_rd_i        (chr_rd_i),
		.chr_addr_i      (chr_addr_i),
		.prg_aout_o      (prg_aout_o),
		.prg_allow_o     (prg_allow_o),
		.prg_dout_o      (prg_dout_o),
		.prg_bus_write_o (prg_bus_write_o),
		.irq_o           (irq_o)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic report_failure();
		error_count++;
		$display("Finished with errors");
		$fatal(1, "stopping at the first error");
	endtask

	// First half of a CPU cycle, outputs are stable when it returns
	task automatic start_cycle(input logic [15:0] addr, input logic [7:0] data,
			input logic rd, input logic wr);
		cpu_i.addr = addr;
		cpu_i.data = data;
		cpu_i.rd   = rd;
		cpu_i.wr   = wr;
		chr_rd_i   = 1'b0;
		repeat (2) @(negedge clk);
	endtask

	// Second half, ce on the fourth clock
	task automatic end_cycle(input logic ppu_rd);
		chr_rd_i = ppu_rd;
		@(negedge clk);
		ce_i = 1'b1;
		@(negedge clk);
		ce_i = 1'b0;
	endtask

	task automatic write_reg(input logic [15:0] addr, input logic [7:0] data);
		start_cycle(addr, data, 1'b0, 1'b1);
		end_cycle(1'b0);
	endtask

	task automatic check_map(input logic [15:0] addr, input logic wr,
			input logic [PRG_AOUT_W-1:0] exp_aout, input logic exp_allow);
		start_cycle(addr, 8'h00, !wr, wr);
		assert (prg_aout_o === exp_aout) else begin
			$display("mismatch prg_aout_o at %h: got %h expected %h", addr, prg_aout_o, exp_aout);
			report_failure();
		end
		assert (prg_allow_o === exp_allow) else begin
			$display("mismatch prg_allow_o at %h wr %h: got %h expected %h",
				addr, wr, prg_allow_o, exp_allow);
			report_failure();
		end
		end_cycle(1'b0);
	endtask

	task automatic check_read(input logic [15:0] addr, input logic [7:0] exp_data);
		logic exp_drive;
		exp_drive = (addr >= ADDR_IRQ_STATUS) && (addr <= ADDR_MUL_HI); // Status and product only
		start_cycle(addr, 8'h00, 1'b1, 1'b0);
		assert (prg_dout_o === exp_data) else begin
			$display("mismatch prg_dout_o at %h: got %h expected %h", addr, prg_dout_o, exp_data);
			report_failure();
		end
		assert (prg_bus_write_o === exp_drive) else begin
			$display("mismatch prg_bus_write_o at %h: got %h expected %h",
				addr, prg_bus_write_o, exp_drive);
			report_failure();
		end
		end_cycle(1'b0);
	endtask

	task automatic ppu_reads(input logic [13:0] addr, input int count);
		int i;
		chr_addr_i = addr;
		for (i = 0; i < count; i++) begin
			start_cycle(16'h0000, 8'h00, 1'b0, 1'b0);
			end_cycle(1'b1);  // PPU read spans the ce
		end
	endtask

	task automatic idle_cycles(input int count);
		int i;
		for (i = 0; i < count; i++) begin
			start_cycle(16'h0000, 8'h00, 1'b0, 1'b0);
			end_cycle(1'b0);
		end
	endtask

	task automatic wait_irq(input logic exp_irq);
		int cycles;
		cycles = 0;
		while (irq_o !== exp_irq && cycles < IRQ_TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		assert (irq_o === exp_irq) else begin
			$display("irq_o did not reach %0d within %0d clock cycles", exp_irq, IRQ_TIMEOUT);
			report_failure();
		end
	endtask

	// Random operand pairs, product bytes read back at $5205/$5206
	task automatic multiply_checks(input int count);
		int          i;
		logic [31:0] rnd;
		logic [7:0]  op_a;
		logic [7:0]  op_b;
		logic [15:0] prod;
		for (i = 0; i < count; i++) begin
			rnd  = $random(seed);
			op_a = rnd[7:0];
			op_b = rnd[15:8];
			prod = 16'(op_a) * 16'(op_b);
			write_reg(ADDR_MUL_LO, op_a);
			write_reg(ADDR_MUL_HI, op_b);
			check_read(ADDR_MUL_LO, prod[7:0]);
			check_read(ADDR_MUL_HI, prod[15:8]);
		end
	endtask

	task automatic check_fields(input int code, input int expected);
		assert (code == expected) else begin
			$display("malformed line in the stimulus file");
			report_failure();
		end
	endtask

	initial begin
		int                    fd;
		int                    code;
		int                    n_cmds;
		int                    count;
		logic [7:0]            cmd;
		logic [15:0]           addr;
		logic [7:0]            data;
		logic [PRG_AOUT_W-1:0] exp_aout;
		logic                  flag_a;
		logic                  flag_b;
		logic [8*128-1:0]      line_buf;

		error_count = 0;
		seed        = 32'hca6886e5;
		arst_n_i    = 1'b0;
		ce_i        = 1'b0;
		cpu_i       = '0;
		chr_rd_i    = 1'b0;
		chr_addr_i  = '0;
		repeat (5) @(negedge clk);
		arst_n_i = 1'b1;
		@(negedge clk);

		fd = $fopen("verification/mmc5_input.txt", "r");
		if (fd == 0) begin
			$display("cannot open the stimulus file");
			report_failure();
		end
		n_cmds = 0;
		while (n_cmds < MAX_COMMANDS) begin
			code = $fscanf(fd, " %c", cmd);
			if (code != 1) begin
				break;  // End of file
			end
			n_cmds++;
			case (cmd)
				"#": code = $fgets(line_buf, fd);
				"W": begin
					code = $fscanf(fd, "%h %h", addr, data);
					check_fields(code, 2);
					write_reg(addr, data);
				end
				"A": begin
					code = $fscanf(fd, "%h %h %h %h", addr, flag_a, exp_aout, flag_b);
					check_fields(code, 4);
					check_map(addr, flag_a, exp_aout, flag_b);
				end
				"R": begin
					code = $fscanf(fd, "%h %h", addr, data);
					check_fields(code, 2);
					check_read(addr, data);
				end
				"N": begin
					code = $fscanf(fd, "%h %h", addr, count);
					check_fields(code, 2);
					ppu_reads(addr[13:0], count);
				end
				"D": begin
					code = $fscanf(fd, "%h", count);
					check_fields(code, 1);
					idle_cycles(count);
				end
				"Q": begin
					code = $fscanf(fd, "%h", flag_a);
					check_fields(code, 1);
					wait_irq(flag_a);
				end
				"M": begin
					code = $fscanf(fd, "%h", count);
					check_fields(code, 1);
					multiply_checks(count);
				end
				default: begin
					$display("unknown command %c in the stimulus file", cmd);
					report_failure();
				end
			endcase
		end
		$fclose(fd);

		if (error_count == 0) begin
			$display("Finished with no errors");
			$finish;
		end else begin
			report_failure();
		end
	end

endmodule

`default_nettype wire

/* verification/mmc5_input.txt */
# Fields in hex. W addr data, A addr wr aout allow, R addr data
# N chr_addr count, D ce_count, Q irq, M operand_pairs
A E000 0 0FE000 1
A FFFF 0 0FFFFF 1
Q 0
R 5204 3F
A 6000 1 3C0000 0
W 5102 02
A 6000 1 3C0000 0
W 5103 01
A 6000 1 3C0000 1
A E000 1 0FE000 0
W 5102 01
A 6000 1 3C0000 0
A 6000 0 3C0000 1
A 5000 0 3C1000 0
W 5113 05
W 5114 81
W 5115 92
W 5116 A3
W 5117 B4
A 6000 0 3CA000 1
A 8000 0 002000 1
A A000 0 024000 1
A C123 0 046123 1
A FFFF 0 069FFF 1
W 5100 00
A 8000 0 068000 1
A A000 0 06A000 1
A E456 0 06E456 1
W 5100 01
A A000 0 026000 1
A C000 0 068000 1
A E000 0 06A000 1
W 5100 02
A 9ABC 0 025ABC 1
A C000 0 046000 1
A E000 0 068000 1
M 8
R 5207 FF
R 8000 FF
W 5203 02
W 5204 80
N 2000 5
Q 0
N 2000 1
Q 1
R 5204 FF
D 1
Q 0
R 5204 7F
R 5204 3F

/* all.f */
verilog/mmc5_cpu_pkg.sv
verilog/mmc5_map_pkg.sv
verilog/mmc5_reg_file.sv
verilog/mmc5_prg_map.sv
verilog/mmc5_scanline_irq.sv
verilog/mmc5_cpu_readback.sv
verilog/mmc5_top.sv
verification/tb_mmc5_top.sv

/* run.sh */
#!/bin/sh
# Build and run the MMC5 CPU core testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -f all.f --top-module tb_mmc5_top -o tb_mmc5_top
./obj_dir/tb_mmc5_top | tee sim.log
if grep -qx "Finished with no errors" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi
